//--- common/tcb_lite_pkg.sv
/* Shared widths, data types and timing constants for the TCB-Lite memory subsystem.
   Modules import it inside their body; port headers use scoped names. */

`default_nettype none

package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    // address width, byte granular
    localparam int unsigned tcb_adr_w = 16;

    // data width for both write and read data
    localparam int unsigned tcb_dat_w = 32;

    // number of byte lanes, one enable bit per lane
    localparam int unsigned tcb_byt_w = tcb_dat_w / 8;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    // byte address
    typedef logic [tcb_adr_w-1:0] tcb_adr_t;

    // write data and read data word
    typedef logic [tcb_dat_w-1:0] tcb_dat_t;

    // byte enables, lane i covers bits [8*i+7:8*i]
    typedef logic [tcb_byt_w-1:0] tcb_byt_t;

    ////////////////////////////////////////////////////////////
    // timing
    ////////////////////////////////////////////////////////////

    // sram read latency in cycles, counted from the request transfer
    // to the edge where rdt and err are valid
    localparam int unsigned tcb_sram_dly = 1;

endpackage : tcb_lite_pkg

`default_nettype wire

//--- common/tcb_lite_if.sv
/* TCB-Lite bus bundle: valid/ready request handshake and a fixed-delay response.
   Managers connect through modport man, subordinates through modport sbd. */

`default_nettype none

interface tcb_lite_if #(
    // response delay in cycles as seen at this point of the bus
    parameter int unsigned DLY = tcb_lite_pkg::tcb_sram_dly
) ();

    import tcb_lite_pkg::*;

    ////////////////////////////////////////////////////////////
    // signals
    ////////////////////////////////////////////////////////////

    // handshake, a transfer happens when both are high
    logic     vld;
    logic     rdy;

    // request
    // wen high for a write, low for a read
    logic     wen;
    tcb_adr_t adr;
    tcb_byt_t byt;
    tcb_dat_t wdt;

    // response, valid DLY cycles after the transfer edge
    logic [tcb_dat_w-1:0] rdt;
    logic     err;

    ////////////////////////////////////////////////////////////
    // modports
    ////////////////////////////////////////////////////////////

    // manager side drives the request and samples the response
    modport man (
        output vld, wen, adr, byt, wdt,
        input  rdy, rdt, err
    );

    // subordinate side, mirror of man
    modport sbd (
        input  vld, wen, adr, byt, wdt,
        output rdy, rdt, err
    );

endinterface : tcb_lite_if

`default_nettype wire

//--- design/tcb_lite_register_request.sv
/* Request path register slice; adds one cycle of latency to the request without bubbles.
   The response passes through combinationally, so DLY grows by one across the slice. */

`default_nettype none

module tcb_lite_register_request #(
    // "POWER" loads only enabled write lanes, "COMPLEXITY" loads the full word
    parameter string OPT = "POWER"
) (
    input  logic       sub,
    input  logic       rst_n,
    tcb_lite_if.sbd    up,
    tcb_lite_if.man    dn
);

    import tcb_lite_pkg::*;

    // request transfer on the upstream side
    logic trn;

    assign trn = up.vld & up.rdy;

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////

    // valid follows upstream whenever the slice can accept
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            dn.vld <= 1'b0;
        end else if (up.rdy) begin
            dn.vld <= up.vld;
        end
    end

    // accept when downstream takes the held request or the slice is empty
    assign up.rdy = dn.rdy | ~dn.vld;

    ////////////////////////////////////////////////////////////
    // request fields
    ////////////////////////////////////////////////////////////

    // payload, loaded only on a transfer
    always_ff @(posedge sub) begin
        if (trn) begin
            dn.wen <= up.wen;
            dn.adr <= up.adr;
            dn.byt <= up.byt;
        end
    end

    // write data, reads leave it untouched
    if (OPT == "POWER") begin : g_power
        // per lane enables, idle lanes do not toggle
        always_ff @(posedge sub) begin
            if (trn & up.wen) begin
                for (int i = 0; i < tcb_byt_w; i++) begin
                    if (up.byt[i]) begin
                        dn.wdt[i*8 +: 8] <= up.wdt[i*8 +: 8];
                    end
                end
            end
        end
    end else begin : g_complexity
        // single enable for the whole word
        always_ff @(posedge sub) begin
            if (trn & up.wen) begin
                dn.wdt <= up.wdt;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    // straight through, the extra cycle is on the request side only
    assign up.rdt = dn.rdt;
    assign up.err = dn.err;

endmodule : tcb_lite_register_request

`default_nettype wire

//--- arbiter/tcb_lite_arbiter.sv
/* Two-manager round-robin arbiter onto one shared TCB-Lite bus.
   Grant is combinational; the response is broadcast to both managers. */

`default_nettype none

module tcb_lite_arbiter (
    input  logic       sub,
    input  logic       rst_n,
    tcb_lite_if.sbd    m0,
    tcb_lite_if.sbd    m1,
    tcb_lite_if.man    dn
);

    ////////////////////////////////////////////////////////////
    // arbitration
    ////////////////////////////////////////////////////////////

    // round-robin pointer
    // 0 favors m0, 1 favors m1
    logic ptr;

    // both managers request in the same cycle
    logic both;

    // selected manager, 0 for m0 and 1 for m1
    logic gnt;

    // transfer on the shared bus
    logic trn;

    assign both = m0.vld & m1.vld;

    // contested cycle uses the pointer, otherwise whoever requests
    // with nobody requesting the select rests on m0
    assign gnt = both ? ptr : m1.vld;

    assign trn = dn.vld & dn.rdy;

    // pointer moves away from the manager that was just served
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= 1'b0;
        end else if (trn) begin
            ptr <= ~gnt;
        end
    end

    ////////////////////////////////////////////////////////////
    // request mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (gnt) begin
            dn.vld = m1.vld;
            dn.wen = m1.wen;
            dn.adr = m1.adr;
            dn.byt = m1.byt;
            dn.wdt = m1.wdt;
        end else begin
            dn.vld = m0.vld;
            dn.wen = m0.wen;
            dn.adr = m0.adr;
            dn.byt = m0.byt;
            dn.wdt = m0.wdt;
        end
    end

    ////////////////////////////////////////////////////////////
    // ready and response
    ////////////////////////////////////////////////////////////

    // only the granted manager sees ready
    // the loser holds its request until the pointer turns
    assign m0.rdy = dn.rdy & ~gnt;
    assign m1.rdy = dn.rdy &  gnt;

    // no response handshake, each manager samples at the known delay
    assign m0.rdt = dn.rdt;
    assign m0.err = dn.err;
    assign m1.rdt = dn.rdt;
    assign m1.err = dn.err;

endmodule : tcb_lite_arbiter

`default_nettype wire

//--- design/tcb_lite_sram.sv
/* Byte-enable synchronous SRAM subordinate, always ready, one cycle read latency.
   Accesses beyond DEPTH words store nothing and answer rdt 0 with err set. */

`default_nettype none

module tcb_lite_sram #(
    // number of words
    parameter int unsigned DEPTH = 256
) (
    input  logic       sub,
    input  logic       rst_n,
    tcb_lite_if.sbd    up
);

    import tcb_lite_pkg::*;

    // low address bits select the byte inside a word
    localparam int unsigned ADR_LSB = $clog2(tcb_byt_w);
    localparam int unsigned IDX_W   = $clog2(DEPTH);

    // storage
    logic [tcb_dat_w-1:0] mem [DEPTH];

    logic [tcb_adr_w-ADR_LSB-1:0] wrd;
    logic [IDX_W-1:0]             idx;
    logic                         in_rng;

    // word address and range check
    assign wrd    = up.adr[tcb_adr_w-1:ADR_LSB];
    assign idx    = wrd[IDX_W-1:0];
    assign in_rng = (wrd < DEPTH);

    // never stalls
    assign up.rdy = 1'b1;

    ////////////////////////////////////////////////////////////
    // write and read ports
    ////////////////////////////////////////////////////////////

    // enabled lanes only
    always_ff @(posedge sub) begin
        if (up.vld & up.wen & in_rng) begin
            for (int i = 0; i < tcb_byt_w; i++) begin
                if (up.byt[i]) begin
                    mem[idx][i*8 +: 8] <= up.wdt[i*8 +: 8];
                end
            end
        end
    end

    // read before write, a write also returns the old word
    always_ff @(posedge sub) begin
        if (up.vld) begin
            up.rdt <= in_rng ? mem[idx] : '0;
        end
    end

    // error flag lasts for exactly the one response
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            up.err <= 1'b0;
        end else begin
            up.err <= up.vld & ~in_rng;
        end
    end

endmodule : tcb_lite_sram

`default_nettype wire

//--- design/tcb_lite_subsystem.sv
/* Shared-memory subsystem top: two managers, arbiter, request slice and SRAM.
   A request transferred at edge N has its response valid after edge N+2. */

`default_nettype none

module tcb_lite_subsystem #(
    parameter string       OPT   = "POWER",
    parameter int unsigned DEPTH = 256
) (
    input  logic                   sub,
    input  logic                   rst_n,
    // manager 0
    input  logic                   m0_vld,
    input  logic                   m0_wen,
    input  tcb_lite_pkg::tcb_adr_t m0_adr,
    input  tcb_lite_pkg::tcb_byt_t m0_byt,
    input  tcb_lite_pkg::tcb_dat_t m0_wdt,
    output logic                   m0_rdy,
    // manager 1
    input  logic                   m1_vld,
    input  logic                   m1_wen,
    input  tcb_lite_pkg::tcb_adr_t m1_adr,
    input  tcb_lite_pkg::tcb_byt_t m1_byt,
    input  tcb_lite_pkg::tcb_dat_t m1_wdt,
    output logic                   m1_rdy,
    // shared response
    output tcb_lite_pkg::tcb_dat_t rdt,
    output logic                   err
);

    import tcb_lite_pkg::*;

    ////////////////////////////////////////////////////////////
    // buses
    ////////////////////////////////////////////////////////////

    // manager side and arbiter output see slice plus sram delay
    tcb_lite_if #(.DLY(tcb_sram_dly + 1)) m0_if  ();
    tcb_lite_if #(.DLY(tcb_sram_dly + 1)) m1_if  ();
    tcb_lite_if #(.DLY(tcb_sram_dly + 1)) arb_if ();
    // slice output sees only the sram
    tcb_lite_if #(.DLY(tcb_sram_dly))     mem_if ();

    // plain ports onto the manager buses
    assign m0_if.vld = m0_vld;
    assign m0_if.wen = m0_wen;
    assign m0_if.adr = m0_adr;
    assign m0_if.byt = m0_byt;
    assign m0_if.wdt = m0_wdt;
    assign m0_rdy    = m0_if.rdy;

    assign m1_if.vld = m1_vld;
    assign m1_if.wen = m1_wen;
    assign m1_if.adr = m1_adr;
    assign m1_if.byt = m1_byt;
    assign m1_if.wdt = m1_wdt;
    assign m1_rdy    = m1_if.rdy;

    // response is the same on both manager buses
    assign rdt = m0_if.rdt;
    assign err = m0_if.err;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    tcb_lite_arbiter i_arb (
        .sub   (sub),
        .rst_n (rst_n),
        .m0    (m0_if),
        .m1    (m1_if),
        .dn    (arb_if)
    );

    tcb_lite_register_request #(.OPT(OPT)) i_reg (
        .sub   (sub),
        .rst_n (rst_n),
        .up    (arb_if),
        .dn    (mem_if)
    );

    tcb_lite_sram #(.DEPTH(DEPTH)) i_mem (
        .sub   (sub),
        .rst_n (rst_n),
        .up    (mem_if)
    );

endmodule : tcb_lite_subsystem

`default_nettype wire

//--- testbench/tcb_lite_subsystem_chk.sv
/* Port checker for the subsystem: arbitration, stalled requests and reset.
   Bound onto every tcb_lite_subsystem instance by the bind below the module. */

`default_nettype none

module tcb_lite_subsystem_chk (
    input logic                   sub,
    input logic                   rst_n,
    input logic                   m0_vld,
    input logic                   m0_wen,
    input tcb_lite_pkg::tcb_adr_t m0_adr,
    input tcb_lite_pkg::tcb_byt_t m0_byt,
    input tcb_lite_pkg::tcb_dat_t m0_wdt,
    input logic                   m0_rdy,
    input logic                   m1_vld,
    input logic                   m1_wen,
    input tcb_lite_pkg::tcb_adr_t m1_adr,
    input tcb_lite_pkg::tcb_byt_t m1_byt,
    input tcb_lite_pkg::tcb_dat_t m1_wdt,
    input logic                   m1_rdy,
    input logic                   err
);

    // a contested cycle has exactly one winner, the loser sees rdy low
    a_one_gnt: assert property (@(posedge sub) disable iff (!rst_n)
        m0_vld && m1_vld |-> m0_rdy != m1_rdy)
        else $error("a contested cycle did not grant exactly one manager");

    // round robin, the loser of a contested cycle is served next
    a_rr_turn: assert property (@(posedge sub) disable iff (!rst_n)
        m0_vld && m1_vld |=> ($past(m0_rdy) ? m1_rdy : m0_rdy))
        else $error("the loser of a contested cycle was not served next");

    // stalled request holds vld and its fields
    a_m0_hold: assert property (@(posedge sub) disable iff (!rst_n)
        m0_vld && !m0_rdy |=> m0_vld && $stable({m0_wen, m0_adr, m0_byt, m0_wdt}))
        else $error("m0 request changed while it was stalled");

    a_m1_hold: assert property (@(posedge sub) disable iff (!rst_n)
        m1_vld && !m1_rdy |=> m1_vld && $stable({m1_wen, m1_adr, m1_byt, m1_wdt}))
        else $error("m1 request changed while it was stalled");

    // no error response while reset is held
    a_rst_err: assert property (@(posedge sub) !rst_n |-> !err)
        else $error("err was high during reset");

endmodule : tcb_lite_subsystem_chk

bind tcb_lite_subsystem tcb_lite_subsystem_chk i_chk (
    .sub (sub), .rst_n (rst_n),
    .m0_vld (m0_vld), .m0_wen (m0_wen), .m0_adr (m0_adr), .m0_byt (m0_byt),
    .m0_wdt (m0_wdt), .m0_rdy (m0_rdy),
    .m1_vld (m1_vld), .m1_wen (m1_wen), .m1_adr (m1_adr), .m1_byt (m1_byt),
    .m1_wdt (m1_wdt), .m1_rdy (m1_rdy),
    .err (err)
);

`default_nettype wire

//--- testbench/tcb_lite_subsystem_tb.sv
/* Testbench for the shared-memory subsystem; replays the golden file on both managers.
   Responses are checked against the file or against a reference memory model. */

`default_nettype none

module tcb_lite_subsystem_tb;

    import tcb_lite_pkg::*;

    localparam int unsigned DEPTH  = 256;
    localparam int          PERIOD = 100;
    // fields per golden line, and room for lines
    localparam int          NFLD   = 7;
    localparam int          MAXLN  = 32;
    // words cleared to a known pattern before the golden lines
    localparam int          NPRE   = 16;

    logic     sub;
    logic     rst_n;
    logic     m0_vld;
    logic     m0_wen;
    tcb_adr_t m0_adr;
    tcb_byt_t m0_byt;
    tcb_dat_t m0_wdt;
    logic     m0_rdy;
    logic     m1_vld;
    logic     m1_wen;
    tcb_adr_t m1_adr;
    tcb_byt_t m1_byt;
    tcb_dat_t m1_wdt;
    logic     m1_rdy;
    tcb_dat_t rdt;
    logic     err;

    logic [31:0] gold [MAXLN*NFLD];
    tcb_dat_t    model [DEPTH];
    int          nlines;
    int          cnt = 0;
    int          errors = 0;
    int          done_tests = 0;
    int          failed = 0;
    int          terr [MAXLN+1];
    int          pend [MAXLN+1];
    // last manager that won the bus, none yet after reset
    bit          served = 1'b0;
    bit          last_mgr = 1'b0;
    integer      seed = 32'h707b;

    // responses still in flight, in transfer order
    int       due_q [$];
    int       tst_q [$];
    bit       mgr_q [$];
    bit       chk_q [$];
    tcb_dat_t rdt_q [$];
    logic     err_q [$];

    tcb_lite_subsystem #(.OPT("POWER"), .DEPTH(DEPTH)) i_dut (
        .sub (sub), .rst_n (rst_n),
        .m0_vld (m0_vld), .m0_wen (m0_wen), .m0_adr (m0_adr), .m0_byt (m0_byt),
        .m0_wdt (m0_wdt), .m0_rdy (m0_rdy),
        .m1_vld (m1_vld), .m1_wen (m1_wen), .m1_adr (m1_adr), .m1_byt (m1_byt),
        .m1_wdt (m1_wdt), .m1_rdy (m1_rdy),
        .rdt (rdt), .err (err)
    );

    initial begin
        sub = 1'b0;
        forever #(PERIOD/2) sub = ~sub;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // initial word contents, built from the whole byte address
    function automatic tcb_dat_t fill(input tcb_adr_t adr);
        return {~adr, adr};
    endfunction

    // enabled lanes take the new byte, the rest keep the old one
    function automatic tcb_dat_t merge(input tcb_dat_t old, input tcb_dat_t wdt,
                                       input tcb_byt_t byt);
        tcb_dat_t res;
        res = old;
        for (int i = 0; i < tcb_byt_w; i++) begin
            if (byt[i]) begin
                res[i*8 +: 8] = wdt[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_rdt(input int t, input string name, input tcb_dat_t got,
                             input tcb_dat_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            terr[t]++;
        end
    endtask

    task automatic check_err(input int t, input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
            terr[t]++;
        end
    endtask

    task automatic check_rdy(input int t, input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
            terr[t]++;
        end
    endtask

    task automatic report_test(input int t);
        done_tests++;
        if (terr[t] != 0) begin
            failed++;
        end
        $display("test %0d (%s) %s", t, (t == 0) ? "preload" : "golden line",
                 (terr[t] == 0) ? "ok" : "FAILED");
    endtask

    // one transfer on the shared bus, response due two edges later
    task automatic record(input int t, input bit mgr, input logic wen, input tcb_adr_t adr,
                          input tcb_byt_t byt, input tcb_dat_t wdt, input bit from_model,
                          input tcb_dat_t f_rdt, input logic f_err, input bit chk);
        int       wrd;
        bit       inr;
        tcb_dat_t old;
        wrd = int'(adr) / tcb_byt_w;
        inr = (wrd < DEPTH);
        old = inr ? model[wrd] : '0;
        // old word goes back on reads and writes alike
        if (wen && inr) begin
            model[wrd] = merge(old, wdt, byt);
        end
        due_q.push_back(cnt + 2);
        tst_q.push_back(t);
        mgr_q.push_back(mgr);
        chk_q.push_back(chk);
        rdt_q.push_back(from_model ? old : f_rdt);
        err_q.push_back(from_model ? !inr : f_err);
        served   = 1'b1;
        last_mgr = mgr;
    endtask

    ////////////////////////////////////////////////////////////
    // request driver
    ////////////////////////////////////////////////////////////

    // sel 0 is m0, 1 is m1, 2 is both with m1 taking a seeded random access
    task automatic run_line(input int t, input int sel, input logic wen, input tcb_adr_t adr,
                            input tcb_byt_t byt, input tcb_dat_t wdt, input tcb_dat_t e_rdt,
                            input logic e_err, input bit chk);
        bit     done0;
        bit     done1;
        bit     win;
        integer r;
        done0 = (sel == 1);
        done1 = (sel == 0);
        pend[t] += (done0 ? 0 : 1) + (done1 ? 0 : 1);
        m0_vld = !done0;
        m0_wen = wen;
        m0_adr = adr;
        m0_byt = byt;
        m0_wdt = wdt;
        m1_vld = !done1;
        if (sel == 2) begin
            // random word in 8..15, away from the golden addresses
            r      = $random(seed);
            m1_wen = r[8];
            m1_byt = r[7:4];
            m1_adr = tcb_adr_t'((8 + r[2:0]) * tcb_byt_w);
            m1_wdt = $random(seed);
        end else begin
            m1_wen = wen;
            m1_adr = adr;
            m1_byt = byt;
            m1_wdt = wdt;
        end
        while (!(done0 && done1)) begin
            @(posedge sub);
            if (!done0 && !done1) begin
                // contested, the manager not served last wins, m0 right after reset
                win = served ? ~last_mgr : 1'b0;
                check_rdy(t, "m0_rdy", m0_rdy, ~win);
                check_rdy(t, "m1_rdy", m1_rdy, win);
            end else if (!done0) begin
                check_rdy(t, "m0_rdy", m0_rdy, 1'b1);
            end else begin
                check_rdy(t, "m1_rdy", m1_rdy, 1'b1);
            end
            if (!done0 && m0_rdy) begin
                record(t, 1'b0, m0_wen, m0_adr, m0_byt, m0_wdt, 1'b0, e_rdt, e_err, chk);
                done0 = 1'b1;
            end else if (!done1 && m1_rdy) begin
                record(t, 1'b1, m1_wen, m1_adr, m1_byt, m1_wdt, sel == 2, e_rdt, e_err, chk);
                done1 = 1'b1;
            end
            @(negedge sub);
            // the loser keeps its request untouched
            if (done0) begin
                m0_vld = 1'b0;
            end
            if (done1) begin
                m1_vld = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // response checker
    ////////////////////////////////////////////////////////////

    // response is stable across the falling edge before the second rising edge
    initial begin
        int       t;
        string    who;
        tcb_dat_t exp_rdt;
        forever begin
            @(negedge sub);
            cnt++;
            while (due_q.size() > 0 && due_q[0] <= cnt) begin
                void'(due_q.pop_front());
                t       = tst_q.pop_front();
                who     = mgr_q.pop_front() ? "m1" : "m0";
                exp_rdt = rdt_q.pop_front();
                check_err(t, {"err (", who, ")"}, err, err_q.pop_front());
                if (chk_q.pop_front()) begin
                    check_rdt(t, {"rdt (", who, ")"}, rdt, exp_rdt);
                end
                pend[t]--;
                if (pend[t] == 0) begin
                    report_test(t);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int base;
        rst_n  = 1'b0;
        m0_vld = 1'b0;
        m0_wen = 1'b0;
        m0_adr = '0;
        m0_byt = '0;
        m0_wdt = '0;
        m1_vld = 1'b0;
        m1_wen = 1'b0;
        m1_adr = '0;
        m1_byt = '0;
        m1_wdt = '0;
        // filler entries never look like a select field
        for (int i = 0; i < MAXLN*NFLD; i++) begin
            gold[i] = {16'hdead, 16'(i)};
        end
        $readmemh("testbench/tcb_lite_golden.txt", gold);
        nlines = 0;
        while (nlines < MAXLN && gold[nlines*NFLD] <= 2) begin
            nlines++;
        end
        repeat (8) @(posedge sub);
        @(negedge sub);
        rst_n = 1'b1;
        @(negedge sub);
        // known contents for the words under test, through m1
        for (int i = 0; i < NPRE; i++) begin
            run_line(0, 1, 1'b1, 16'(i*tcb_byt_w), '1, fill(16'(i*tcb_byt_w)), '0, 1'b0, 1'b0);
        end
        for (int n = 0; n < nlines; n++) begin
            base = n*NFLD;
            run_line(n + 1, int'(gold[base]), gold[base+1][0], tcb_adr_t'(gold[base+2]),
                     tcb_byt_t'(gold[base+3]), gold[base+4], gold[base+5],
                     gold[base+6][0], 1'b1);
        end
        if (nlines == 0) begin
            $display("the golden file holds no transactions");
            errors++;
        end
        while (due_q.size() > 0) begin
            @(negedge sub);
        end
        $display("tests %0d, failed %0d, errors %0d", done_tests, failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // twenty cycles per golden line
    initial begin
        #(PERIOD);
        #(nlines * 20 * PERIOD);
        $display("timeout, the run did not finish, %0d responses outstanding", due_q.size());
        $display("Some tests failed");
        $finish;
    end

endmodule : tcb_lite_subsystem_tb

`default_nettype wire

//--- testbench/tcb_lite_golden.txt
// sel (0 m0, 1 m1, 2 both)  wen  adr  byt  wdt  expected rdt  expected err
// a both line sends a seeded random access on m1, checked against the model
0 1 0000 f 11223344 ffff0000 0
0 0 0000 0 00000000 11223344 0
0 1 0004 f a5a5a5a5 fffb0004 0
0 1 0004 3 0000beef a5a5a5a5 0
0 1 0004 8 7f000000 a5a5beef 0
0 0 0004 0 00000000 7fa5beef 0
1 1 0008 5 00cc00dd fff70008 0
1 0 0008 0 00000000 ffcc00dd 0
0 1 0400 f deadbeef 00000000 1
0 0 0800 0 00000000 00000000 1
0 0 0000 0 00000000 11223344 0
1 0 0004 0 00000000 7fa5beef 0
2 1 000c f 01020304 fff3000c 0
2 0 000c 0 00000000 01020304 0
2 1 0010 2 0000ab00 ffef0010 0
2 0 0010 0 00000000 ffefab10 0
0 0 0008 0 00000000 ffcc00dd 0

//--- vlog.f
common/tcb_lite_pkg.sv
common/tcb_lite_if.sv
design/tcb_lite_register_request.sv
arbiter/tcb_lite_arbiter.sv
design/tcb_lite_sram.sv
design/tcb_lite_subsystem.sv
testbench/tcb_lite_subsystem_chk.sv
testbench/tcb_lite_subsystem_tb.sv

//--- Makefile
# Verilator build and run for the TCB-Lite subsystem testbench

TOOL  ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP   ?= tcb_lite_subsystem_tb
FLIST ?= vlog.f
BUILD ?= obj_dir
LOG   ?= sim.log
PASS  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
